// ==== all.f ====
source/denise_pkg.sv
source/denise_regs.sv
source/denise_bitplanes.sv
source/denise_playfields.sv
source/denise_colortable.sv
source/denise_video.sv
tests/denise_video_asserts.sv
tests/denise_video_tb.sv

// ==== Bender.yml ====
package:
  name: denise_video

sources:
  - files:
      - source/denise_pkg.sv
      - source/denise_regs.sv
      - source/denise_bitplanes.sv
      - source/denise_playfields.sv
      - source/denise_colortable.sv
      - source/denise_video.sv
  - target: test
    files:
      - tests/denise_video_asserts.sv
      - tests/denise_video_tb.sv

// ==== tests/denise_video_tb.sv ====
/*
 * denise video testbench
 * fills the color table, runs fixed and random bitplane lines through single
 * and dual playfield modes in aga and ocs, checks rgb and nplayfield per pixel
 */

`timescale 1ns/1ps

module denise_video_tb;

  localparam int BPL_WIDTH    = 16;
  localparam int LINE_CYCLES  = 32;  // control writes, plane writes, load, 16 pixels
  localparam int NUM_LINES    = 17;
  localparam int SETUP_CYCLES = 300; // reset, color fill and rewrite
  localparam int TOTAL_CYCLES = SETUP_CYCLES + NUM_LINES * LINE_CYCLES;

  logic                  clk;
  logic                  rst;
  logic                  aga;
  logic                  reg_wr;
  denise_pkg::reg_addr_t reg_addr;
  denise_pkg::reg_data_t reg_data;
  logic                  bpl_wr;
  logic [2:0]            bpl_sel;
  logic [BPL_WIDTH-1:0]  bpl_word;
  logic                  bpl_load;
  logic                  shift;
  logic [2:1]            nplayfield;
  denise_pkg::rgb_t      rgb;

  logic [BPL_WIDTH-1:0]  plane_words [8]; // plane 1 at index 0
  denise_pkg::rgb_t      color_model [256];
  logic [4:0]            con0_model;      // dblpf, bpu
  logic [6:0]            con2_model;      // pf2pri, pf2p, pf1p
  logic [2:0]            con3_model;      // pf2of
  int                    seed;

  denise_video #(.BPL_WIDTH(BPL_WIDTH)) denise_video_i
  (
    .clk        (clk),
    .rst        (rst),
    .aga        (aga),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_data   (reg_data),
    .bpl_wr     (bpl_wr),
    .bpl_sel    (bpl_sel),
    .bpl_word   (bpl_word),
    .bpl_load   (bpl_load),
    .shift      (shift),
    .nplayfield (nplayfield),
    .rgb        (rgb)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial
  begin
    #(2 * TOTAL_CYCLES * 4);
    $display("Timeout, the test sequence did not finish within %0d cycles", 2 * TOTAL_CYCLES);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  // the first bound assertion failure ends the run
  initial
  begin
    wait (denise_video_i.asserts_i.fail_count != 0);
    $display("A bound assertion failed");
    $display("Checks failed");
    $fatal(1, "bound assertion failed");
  end

  // color rule {i, i xor ff, i xor 5a}
  function automatic denise_pkg::rgb_t fill_color(input int i);
    logic [7:0] v;
    v = i[7:0];
    return {v, v ^ 8'hFF, v ^ 8'h5A};
  endfunction

  function automatic logic [7:0] pf2_offset(input logic [2:0] code);
    case (code)
      3'd0: return 8'd0;
      3'd1: return 8'd2;
      3'd2: return 8'd4;
      3'd3: return 8'd8;
      3'd4: return 8'd16;
      3'd5: return 8'd32;
      3'd6: return 8'd64;
      default: return 8'd128;
    endcase
  endfunction

  // plane bits seen for one pixel after plane count masking
  function automatic denise_pkg::bpl_bits_t visible_bits(input int pixel);
    denise_pkg::bpl_bits_t bits;
    int limit;
    int planes;
    limit  = aga ? 8 : 6;
    planes = (int'(con0_model[3:0]) > limit) ? limit : int'(con0_model[3:0]);
    for (int k = 0; k < 8; k++)
    begin
      bits[k] = (k < planes) ? plane_words[k][BPL_WIDTH-1-pixel] : 1'b0;
    end
    return bits;
  endfunction

  function automatic logic [2:1] expected_np(input denise_pkg::bpl_bits_t bits);
    if (con0_model[4])
      return {|{bits[7], bits[5], bits[3], bits[1]}, |{bits[6], bits[4], bits[2], bits[0]}};
    else
      return {|bits, 1'b0}; // single playfield reports as playfield 2
  endfunction

  function automatic denise_pkg::color_idx_t expected_index(input denise_pkg::bpl_bits_t bits);
    logic [7:0] pf1;
    logic [7:0] pf2;
    logic [7:0] idx;
    pf1 = {4'h0, bits[6], bits[4], bits[2], bits[0]}; // odd planes
    pf2 = {4'h0, bits[7], bits[5], bits[3], bits[1]}; // even planes
    if (con0_model[4])
    begin
      if (pf1 != 0 && pf2 != 0)
        idx = con2_model[6] ? pf2 + pf2_offset(aga ? con3_model : 3'd3) : pf1;
      else if (pf1 != 0)
        idx = pf1;
      else if (pf2 != 0)
        idx = pf2 + pf2_offset(aga ? con3_model : 3'd3);
      else
        idx = 8'd0; // background
    end
    else if (!aga && con2_model[5:3] > 3'd5 && bits[4])
      idx = 8'd16;
    else
      idx = bits;
    return aga ? idx : (idx & 8'h1F); // ocs reaches 32 colors
  endfunction

  task automatic check_value(input string name, input logic [23:0] expected,
                             input logic [23:0] actual);
    assert (actual === expected)
    else
    begin
      $display("ERROR %s expected 0x%06h actual 0x%06h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic write_reg(input denise_pkg::reg_addr_t addr, input denise_pkg::reg_data_t data);
    reg_wr   = 1'b1;
    reg_addr = addr;
    reg_data = data;
    @(posedge clk);
    #1;
    reg_wr = 1'b0;
  endtask

  task automatic set_control(input logic mode_aga, input logic [4:0] con0,
                             input logic [6:0] con2, input logic [2:0] con3);
    aga        = mode_aga;
    con0_model = con0;
    con2_model = con2;
    con3_model = con3;
    write_reg(denise_pkg::REG_BPLCON0, 24'(con0));
    write_reg(denise_pkg::REG_BPLCON2, 24'(con2));
    write_reg(denise_pkg::REG_BPLCON3, 24'(con3));
  endtask

  // pointer write then auto-incremented data writes that wrap at 256
  task automatic write_colors(input int first, input int count, input denise_pkg::rgb_t flip);
    write_reg(denise_pkg::REG_COLOR_PTR, 24'(first));
    for (int i = 0; i < count; i++)
    begin
      color_model[(first + i) % 256] = fill_color((first + i) % 256) ^ flip;
      write_reg(denise_pkg::REG_COLOR_DATA, color_model[(first + i) % 256]);
    end
  endtask

  task automatic set_words(input logic [8*BPL_WIDTH-1:0] words); // {plane 8 .. plane 1}
    for (int k = 0; k < 8; k++)
    begin
      plane_words[k] = words[BPL_WIDTH*k +: BPL_WIDTH];
    end
  endtask

  task automatic random_words();
    for (int k = 0; k < 8; k++)
    begin
      plane_words[k] = BPL_WIDTH'($random(seed));
    end
  endtask

  // plane writes and load then one shift per pixel with rgb a cycle behind
  task automatic run_line();
    denise_pkg::bpl_bits_t  bits;
    denise_pkg::color_idx_t prev_idx;
    for (int k = 0; k < 8; k++)
    begin
      bpl_wr   = 1'b1;
      bpl_sel  = 3'(k);
      bpl_word = plane_words[k];
      @(posedge clk);
      #1;
    end
    bpl_wr   = 1'b0;
    bpl_load = 1'b1;
    @(posedge clk); // pixel 0 on bpldata
    #1;
    bpl_load = 1'b0;
    shift    = 1'b1;
    for (int p = 0; p < BPL_WIDTH; p++)
    begin
      bits = visible_bits(p);
      @(negedge clk);
      check_value("nplayfield", 24'(expected_np(bits)), 24'(nplayfield));
      if (p > 0)
        check_value("rgb", color_model[prev_idx], rgb);
      prev_idx = expected_index(bits);
      @(posedge clk);
      #1;
    end
    shift = 1'b0;
    @(negedge clk);
    check_value("rgb", color_model[prev_idx], rgb); // last pixel
    @(posedge clk);
    #1;
  endtask

  initial
  begin
    seed       = 32'h0d1a_4b02;
    rst        = 1'b1;
    aga        = 1'b1;
    reg_wr     = 1'b0;
    reg_addr   = '0;
    reg_data   = '0;
    bpl_wr     = 1'b0;
    bpl_sel    = '0;
    bpl_word   = '0;
    bpl_load   = 1'b0;
    shift      = 1'b0;
    con0_model = '0;
    con2_model = '0;
    con3_model = '0;
    set_words('0);
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_value("rgb", 24'h0, rgb);
    check_value("nplayfield", 24'h0, 24'(nplayfield));
    @(posedge clk);
    #1;
    write_colors(0, 256, 24'h0);

    // aga single playfield with 8 planes then 4
    set_words({16'h9E37, 16'h6996, 16'h3C3C, 16'h0FF0, 16'hFF00, 16'hF0F0, 16'hCCCC, 16'hAAAA});
    set_control(1'b1, 5'h08, 7'h00, 3'd0);
    run_line();
    set_control(1'b1, 5'h04, 7'h00, 3'd0);
    run_line();

    // aga dual playfield with pf2 over pf1 at offset 128 then pf1 over pf2 at offset 0
    set_words({16'h0006, 16'h0030, 16'h0300, 16'h3000, 16'h00F0, 16'h0F00, 16'hAAAA, 16'hCCCC});
    set_control(1'b1, 5'h18, 7'h40, 3'd7);
    run_line();
    set_control(1'b1, 5'h18, 7'h00, 3'd0);
    run_line();

    // ocs keeps offset 8 and limits planes to 6 and colors to 32
    set_control(1'b0, 5'h18, 7'h40, 3'd5);
    run_line();
    set_words({16'h9E37, 16'h6996, 16'h3C3C, 16'h0FF0, 16'hFF00, 16'hF0F0, 16'hCCCC, 16'hAAAA});
    set_control(1'b0, 5'h08, 7'h00, 3'd0);
    run_line();

    // pf2p of 6 with plane 5 set forces 16 in ocs and keeps the raw index in aga
    set_words({16'h0000, 16'h0000, 16'hFF00, 16'hF0F0, 16'h3C3C, 16'h0FF0, 16'hCCCC, 16'hAAAA});
    set_control(1'b0, 5'h06, 7'h30, 3'd0);
    run_line();
    set_control(1'b1, 5'h06, 7'h30, 3'd0);
    run_line();

    // pointer rewrite across the wrap shown at indices fe ff 00 01
    write_colors(254, 4, 24'hC33C96);
    set_words({{7{16'hC000}}, 16'h5000});
    set_control(1'b1, 5'h08, 7'h00, 3'd0);
    run_line();

    for (int n = 0; n < 8; n++)
    begin
      random_words();
      set_control(1'b1, {n[0], 4'd8}, 7'($random(seed)), 3'(n));
      run_line();
    end

    if (denise_video_i.asserts_i.fail_count == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
    begin
      $display("%0d bound assertion failures", denise_video_i.asserts_i.fail_count);
      $display("Checks failed");
      $fatal(1, "bound assertions failed");
    end
  end

endmodule

// ==== tests/denise_video_asserts.sv ====
/*
 * denise video checker
 * reset state of rgb, one cycle color lookup against a shadow color table,
 * and the single playfield rule for nplayfield
 */

`timescale 1ns/1ps

module denise_video_asserts
(
  input logic                   clk,
  input logic                   rst,
  input logic                   aga,
  input logic                   dblpf,
  input denise_pkg::color_idx_t plfdata,
  input logic                   color_wr,
  input denise_pkg::color_idx_t color_addr,
  input denise_pkg::rgb_t       color_data,
  input logic [2:1]             nplayfield,
  input denise_pkg::rgb_t       rgb
);

  int unsigned            fail_count = 0;    // read by the testbench at the end
  denise_pkg::rgb_t       shadow [256];      // copy of the color writes
  logic [255:0]           written = '0;      // entries holding a known color
  denise_pkg::color_idx_t lookup_idx;
  denise_pkg::rgb_t       exp_rgb;
  logic                   exp_known;

  always @(posedge clk)
  begin
    if (color_wr)
    begin
      shadow[color_addr]  <= color_data;
      written[color_addr] <= 1'b1;
    end
  end

  assign lookup_idx = aga ? plfdata : (plfdata & 8'h1F); // ocs, modulo 32
  assign exp_rgb    = shadow[lookup_idx];
  assign exp_known  = written[lookup_idx];

  rgb_after_reset: assert property (@(posedge clk) $fell(rst) |-> rgb == '0)
  else
  begin
    fail_count = fail_count + 1;
    $error("rgb not zero in the cycle after reset");
  end

  // old entry if the same entry is written on the lookup edge
  rgb_lookup: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) && $past(exp_known) |-> rgb == $past(exp_rgb))
  else
  begin
    fail_count = fail_count + 1;
    $error("rgb differs from the color entry of the previous index");
  end

  single_no_pf1: assert property (@(posedge clk) disable iff (rst) !dblpf |-> !nplayfield[1])
  else
  begin
    fail_count = fail_count + 1;
    $error("playfield 1 flagged in single playfield mode");
  end

endmodule

bind denise_video denise_video_asserts asserts_i
(
  .clk        (clk),
  .rst        (rst),
  .aga        (aga),
  .dblpf      (dblpf),
  .plfdata    (plfdata),
  .color_wr   (color_wr),
  .color_addr (color_addr),
  .color_data (color_data),
  .nplayfield (nplayfield),
  .rgb        (rgb)
);

// ==== source/denise_video.sv ====
/*
 * denise video pixel path
 * control registers, bitplane shifters, playfield engine and color table
 * wired from cpu writes to one rgb pixel per clock
 */

`timescale 1ns/1ps

module denise_video
#(
  parameter int BPL_WIDTH = 16 // bitplane data word width
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  aga,        // aga mode, else ocs/ecs
  input  logic                  reg_wr,     // register write strobe
  input  denise_pkg::reg_addr_t reg_addr,
  input  denise_pkg::reg_data_t reg_data,
  input  logic                  bpl_wr,     // bitplane word write strobe
  input  logic [2:0]            bpl_sel,    // plane number minus 1
  input  logic [BPL_WIDTH-1:0]  bpl_word,
  input  logic                  bpl_load,   // load shifters
  input  logic                  shift,      // next pixel
  output logic [2:1]            nplayfield, // playfield 1,2 valid data
  output denise_pkg::rgb_t      rgb         // pixel color
);

  denise_pkg::bpu_t       bpu;
  logic                   dblpf;
  logic [6:0]             bplcon2;
  logic [2:0]             pf2of;
  logic                   color_wr;
  denise_pkg::color_idx_t color_addr;
  denise_pkg::rgb_t       color_data;
  denise_pkg::bpl_bits_t  bpldata;
  denise_pkg::color_idx_t plfdata;

  denise_regs regs_i
  (
    .clk        (clk),
    .rst        (rst),
    .aga        (aga),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_data   (reg_data),
    .bpu        (bpu),
    .dblpf      (dblpf),
    .bplcon2    (bplcon2),
    .pf2of      (pf2of),
    .color_wr   (color_wr),
    .color_addr (color_addr),
    .color_data (color_data)
  );

  denise_bitplanes #(.BPL_WIDTH(BPL_WIDTH)) bitplanes_i
  (
    .clk      (clk),
    .rst      (rst),
    .bpl_wr   (bpl_wr),
    .bpl_sel  (bpl_sel),
    .bpl_word (bpl_word),
    .bpl_load (bpl_load),
    .shift    (shift),
    .bpu      (bpu),
    .bpldata  (bpldata)
  );

  denise_playfields playfields_i
  (
    .aga        (aga),
    .bpldata    (bpldata),
    .dblpf      (dblpf),
    .pf2of      (pf2of),
    .bplcon2    (bplcon2),
    .nplayfield (nplayfield),
    .plfdata    (plfdata)
  );

  denise_colortable colortable_i
  (
    .clk        (clk),
    .rst        (rst),
    .aga        (aga),
    .color_wr   (color_wr),
    .color_addr (color_addr),
    .color_data (color_data),
    .plfdata    (plfdata),
    .rgb        (rgb)
  );

endmodule

// ==== source/denise_colortable.sv ====
/*
 * denise color table
 * 256 entry rgb register file written from the register block, with a
 * registered lookup of the playfield color index
 */

`timescale 1ns/1ps

module denise_colortable
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   aga,        // aga mode, else ocs/ecs
  input  logic                   color_wr,   // entry write strobe
  input  denise_pkg::color_idx_t color_addr, // entry to write
  input  denise_pkg::rgb_t       color_data, // entry value
  input  denise_pkg::color_idx_t plfdata,    // pixel color index
  output denise_pkg::rgb_t       rgb         // pixel color, one cycle later
);

  localparam denise_pkg::color_idx_t OCS_MASK =
    denise_pkg::color_idx_t'(denise_pkg::OCS_COLORS - 1);

  denise_pkg::rgb_t       color_mem [256]; // color registers
  denise_pkg::color_idx_t lookup_idx;      // index after mode masking

  // ocs reaches only the first 32 entries
  assign lookup_idx = aga ? plfdata : (plfdata & OCS_MASK);

  // cpu side writes
  always_ff @(posedge clk)
  begin
    if (color_wr)
    begin
      color_mem[color_addr] <= color_data;
    end
  end

  // pixel lookup
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rgb <= '0;
    end
    else
    begin
      rgb <= color_mem[lookup_idx]; // old entry if written on this edge
    end
  end

endmodule

// ==== source/denise_playfields.sv ====
/*
 * denise playfield engine
 * builds the color index from the raw plane bits in single or dual
 * playfield mode and flags which playfield holds opaque data
 */

`timescale 1ns/1ps

module denise_playfields
(
  input  logic                   aga,        // aga mode, else ocs/ecs
  input  denise_pkg::bpl_bits_t  bpldata,    // raw plane bits, plane n at bit n-1
  input  logic                   dblpf,      // dual playfield select
  input  logic [2:0]             pf2of,      // playfield 2 offset code
  input  logic [6:0]             bplcon2,    // playfield priority
  output logic [2:1]             nplayfield, // playfield 1,2 valid data
  output denise_pkg::color_idx_t plfdata     // color index out
);

  logic                   pf2pri;    // playfield 2 over playfield 1
  logic [2:0]             pf2p;      // playfield 2 priority code
  logic [7:0]             pf2of_val; // offset added to playfield 2 data
  denise_pkg::color_idx_t pf1_idx;
  denise_pkg::color_idx_t pf2_idx;

  assign pf2pri = bplcon2[6];
  assign pf2p   = bplcon2[5:3];

  // offset code to value, powers of two from 2 with 0 meaning none
  assign pf2of_val = (pf2of == 3'd0) ? 8'd0 : (8'd1 << pf2of);

  // odd planes make playfield 1, even planes playfield 2
  assign pf1_idx = {4'b0000, bpldata[6], bpldata[4], bpldata[2], bpldata[0]};
  assign pf2_idx = {4'b0000, bpldata[7], bpldata[5], bpldata[3], bpldata[1]} + pf2of_val;

  // valid flags
  always_comb
  begin
    if (dblpf)
    begin
      nplayfield[1] = |{bpldata[6], bpldata[4], bpldata[2], bpldata[0]};
      nplayfield[2] = |{bpldata[7], bpldata[5], bpldata[3], bpldata[1]};
    end
    else
    begin
      nplayfield[1] = 1'b0;       // single playfield counts as playfield 2
      nplayfield[2] = |bpldata;
    end
  end

  // priority and index select
  always_comb
  begin
    if (dblpf)
    begin
      if (pf2pri && nplayfield[2])
        plfdata = pf2_idx;
      else if (nplayfield[1])
        plfdata = pf1_idx;
      else if (nplayfield[2])
        plfdata = pf2_idx;        // pf1 transparent, pf2 shows through
      else
        plfdata = 8'd0;           // background color
    end
    else if (!aga && (pf2p > 3'd5) && bpldata[4])
      plfdata = 8'd16;            // ocs quirk, plane 5 forces color 16
    else
      plfdata = bpldata;
  end

endmodule

// ==== source/denise_bitplanes.sv ====
/*
 * denise bitplane shifters
 * eight holding registers loaded by the cpu, copied into eight shift
 * registers on bpl_load and shifted out msb first, one pixel per strobe
 */

`timescale 1ns/1ps

module denise_bitplanes
#(
  parameter int BPL_WIDTH = 16 // bitplane data word width
)
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   bpl_wr,   // holding register write strobe
  input  logic [2:0]             bpl_sel,  // plane number minus 1
  input  logic [BPL_WIDTH-1:0]   bpl_word, // plane data word
  input  logic                   bpl_load, // copy holding regs to shifters
  input  logic                   shift,    // advance shifters by one pixel
  input  denise_pkg::bpu_t       bpu,      // enabled plane count
  output denise_pkg::bpl_bits_t  bpldata   // current pixel, one bit per plane
);

  logic [BPL_WIDTH-1:0]  hold [8];  // holding registers, plane 1 at index 0
  logic [BPL_WIDTH-1:0]  shreg [8]; // pixel shifters
  denise_pkg::bpl_bits_t plane_en;  // planes below bpu
  denise_pkg::bpl_bits_t shift_msb; // raw shifter outputs

  // holding registers
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 8; i++)
      begin
        hold[i] <= '0;
      end
    end
    else if (bpl_wr)
    begin
      hold[bpl_sel] <= bpl_word;
    end
  end

  // shifters, a load on the same edge as a shift wins
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 8; i++)
      begin
        shreg[i] <= '0;
      end
    end
    else if (bpl_load)
    begin
      for (int i = 0; i < 8; i++)
      begin
        shreg[i] <= hold[i];
      end
    end
    else if (shift)
    begin
      for (int i = 0; i < 8; i++)
      begin
        shreg[i] <= {shreg[i][BPL_WIDTH-2:0], 1'b0}; // msb first, zero fill
      end
    end
  end

  // plane enables and shifter msbs
  always_comb
  begin
    for (int i = 0; i < 8; i++)
    begin
      plane_en[i]  = (i < int'(bpu)); // plane i+1 shown only when bpu > i
      shift_msb[i] = shreg[i][BPL_WIDTH-1];
    end
  end

  // disabled planes read as zero
  assign bpldata = shift_msb & plane_en;

endmodule

// ==== source/denise_regs.sv ====
/*
 * denise control registers
 * decodes cpu writes into bplcon0/2/3 fields and turns color data
 * writes into auto-incrementing color table write strobes
 */

`timescale 1ns/1ps

module denise_regs
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  aga,        // aga mode, else ocs/ecs
  input  logic                  reg_wr,     // register write strobe
  input  denise_pkg::reg_addr_t reg_addr,   // register select
  input  denise_pkg::reg_data_t reg_data,   // register write data
  output denise_pkg::bpu_t      bpu,        // plane count, clamped to mode limit
  output logic                  dblpf,      // dual playfield select
  output logic [6:0]            bplcon2,    // playfield priority
  output logic [2:0]            pf2of,      // playfield 2 offset code
  output logic                  color_wr,   // color entry write strobe
  output denise_pkg::color_idx_t color_addr, // color entry being written
  output denise_pkg::rgb_t      color_data  // color entry value
);

  logic [4:0]             bplcon0_q; // dblpf and raw bpu
  logic [6:0]             bplcon2_q;
  logic [2:0]             bplcon3_q; // pf2of field only
  denise_pkg::color_idx_t color_ptr; // auto-increment color pointer
  denise_pkg::bpu_t       bpu_raw;
  denise_pkg::bpu_t       bpu_limit;

  // register writes, visible from the next cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bplcon0_q <= '0;
      bplcon2_q <= '0;
      bplcon3_q <= '0;
      color_ptr <= '0;
    end
    else if (reg_wr)
    begin
      case (reg_addr)
        denise_pkg::REG_BPLCON0:    bplcon0_q <= reg_data[4:0];
        denise_pkg::REG_BPLCON2:    bplcon2_q <= reg_data[6:0];
        denise_pkg::REG_BPLCON3:    bplcon3_q <= reg_data[2:0];
        denise_pkg::REG_COLOR_PTR:  color_ptr <= reg_data[7:0];
        denise_pkg::REG_COLOR_DATA: color_ptr <= color_ptr + 8'd1; // wraps at 256
        default: ;                                                 // unmapped, ignored
      endcase
    end
  end

  // plane count clamp, 8 planes in aga, 6 in ocs
  assign bpu_raw   = bplcon0_q[3:0];
  assign bpu_limit = aga ? denise_pkg::MAX_PLANES_AGA : denise_pkg::MAX_PLANES_OCS;
  assign bpu       = (bpu_raw > bpu_limit) ? bpu_limit : bpu_raw;

  assign dblpf   = bplcon0_q[4];
  assign bplcon2 = bplcon2_q;
  assign pf2of   = aga ? bplcon3_q : 3'd3; // ocs has a fixed offset of 8

  // color data write goes straight to the table on this edge
  assign color_wr   = reg_wr && (reg_addr == denise_pkg::REG_COLOR_DATA);
  assign color_addr = color_ptr;
  assign color_data = reg_data[23:0];

endmodule

// ==== source/denise_pkg.sv ====
/*
 * denise video package
 * shared vector types, register map and plane limits for the pixel path
 */

package denise_pkg;

  // one bit per bitplane, plane n sits at bit n-1
  typedef logic [7:0] bpl_bits_t;

  typedef logic [7:0] color_idx_t; // color table index
  typedef logic [23:0] rgb_t;      // 8 bits each of red, green, blue

  // cpu register port
  typedef logic [2:0] reg_addr_t;  // register select
  typedef logic [23:0] reg_data_t; // write data, widest user is a color entry

  typedef logic [3:0] bpu_t;       // enabled plane count, 0 to 8

  // register map
  // bplcon0: [4] dblpf, [3:0] bpu
  // bplcon2: [6] pf2pri, [5:3] pf2p, [2:0] pf1p
  // bplcon3: [2:0] pf2of
  localparam reg_addr_t REG_BPLCON0    = 3'd0;
  localparam reg_addr_t REG_BPLCON2    = 3'd1;
  localparam reg_addr_t REG_BPLCON3    = 3'd2;
  localparam reg_addr_t REG_COLOR_PTR  = 3'd3; // sets the color write pointer
  localparam reg_addr_t REG_COLOR_DATA = 3'd4; // writes one entry, pointer steps

  // plane count limits per chipset mode
  localparam bpu_t MAX_PLANES_AGA = 4'd8;
  localparam bpu_t MAX_PLANES_OCS = 4'd6;

  // color table reach in ocs/ecs mode
  localparam int OCS_COLORS = 32;

endpackage
